/* Bender.yml */
package:
  name: mem_stage

sources:
  - common/lsu_pkg.sv
  - common/access_if.sv
  - hw/lsu/lane_align.sv
  - hw/lsu/axi_read_fsm.sv
  - hw/lsu/axi_write_fsm.sv
  - hw/lsu/load_extract.sv
  - hw/mem_stage_ctrl.sv
  - hw/mem_stage_top.sv
  - target: simulation
    files:
      - dv/mem_stage_props.sv
      - dv/tb_mem_stage.sv

/* build.f */
common/lsu_pkg.sv
common/access_if.sv
hw/lsu/lane_align.sv
hw/lsu/axi_read_fsm.sv
hw/lsu/axi_write_fsm.sv
hw/lsu/load_extract.sv
hw/mem_stage_ctrl.sv
hw/mem_stage_top.sv
dv/mem_stage_props.sv
dv/tb_mem_stage.sv

/* common/access_if.sv */
`timescale 1ns/10ps
`default_nettype none

// lane plan of the access currently held in the stage
interface access_if #(
	parameter int ADDR_W = lsu_pkg::addr_w,
	parameter int BUS_W  = lsu_pkg::bus_w
);

	lsu_pkg::mem_op_e   op;
	logic               need_second;
	logic [ADDR_W-1:0]  first_addr;
	logic [ADDR_W-1:0]  second_addr;
	logic [BUS_W/8-1:0] first_strb;
	logic [BUS_W/8-1:0] second_strb;
	logic [BUS_W-1:0]   wdata;

	modport planner (
		output op, need_second, first_addr, second_addr,
		output first_strb, second_strb, wdata
	);

	modport user (
		input op, need_second, first_addr, second_addr,
		input first_strb, second_strb, wdata
	);

endinterface

`default_nettype wire

/* common/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

	// ------------------------------------------------------------
	// widths
	// ------------------------------------------------------------
	localparam int addr_w    = 32;
	localparam int xlen      = 32;
	localparam int bus_w     = 64;
	localparam int strb_w    = bus_w / 8;
	localparam int reg_idx_w = 5;

	// byte mask inside one 4-byte group
	typedef logic [3:0] grp_mask_t;

	typedef enum logic [3:0] {
		MEM_LB,
		MEM_LH,
		MEM_LW,
		MEM_LBU,
		MEM_LHU,
		MEM_SB,
		MEM_SH,
		MEM_SW
	} mem_op_e;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_WAIT_AR,
		RD_WAIT_R,
		RD_IDLE2
	} rd_state_e;

	typedef enum logic [2:0] {
		WR_IDLE,
		WR_WAIT_AW,
		WR_WAIT_W,
		WR_WAIT_B,
		WR_IDLE2
	} wr_state_e;

	function automatic logic is_load(mem_op_e op);
		return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
	endfunction

	function automatic logic is_store(mem_op_e op);
		return op inside {MEM_SB, MEM_SH, MEM_SW};
	endfunction

	// bytes touched, packed from bit 0
	function automatic grp_mask_t size_mask(mem_op_e op);
		case (op)
			MEM_LW, MEM_SW:          return 4'b1111;
			MEM_LH, MEM_LHU, MEM_SH: return 4'b0011;
			default:                 return 4'b0001;
		endcase
	endfunction

endpackage

`default_nettype wire

/* dv/mem_stage_props.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage_props #(
	parameter int ADDR_W = lsu_pkg::addr_w,
	parameter int BUS_W  = lsu_pkg::bus_w
) (
	input wire               clock,
	input wire               reset,
	input wire               ar_valid,
	input wire               ar_ready,
	input wire [ADDR_W-1:0]  ar_addr,
	input wire               aw_valid,
	input wire               aw_ready,
	input wire [ADDR_W-1:0]  aw_addr,
	input wire               w_valid,
	input wire [BUS_W/8-1:0] w_strb
);

	// read by the testbench summary
	int fail_count = 0;

	// request held until accepted
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
	else begin
		fail_count++;
		$error("ar_valid or ar_addr changed before ar_ready");
	end

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
	else begin
		fail_count++;
		$error("aw_valid or aw_addr changed before aw_ready");
	end

	w_strb_set: assert property (@(posedge clock) disable iff (reset)
		w_valid |-> w_strb != '0)
	else begin
		fail_count++;
		$error("w_valid high with an empty w_strb");
	end

	// one engine at a time
	one_channel: assert property (@(posedge clock) disable iff (reset)
		!(ar_valid && aw_valid))
	else begin
		fail_count++;
		$error("ar_valid and aw_valid high together");
	end

endmodule

bind mem_stage_top mem_stage_props #(.ADDR_W(ADDR_W), .BUS_W(BUS_W)) u_props (
	.clock(clock), .reset(reset),
	.ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
	.aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
	.w_valid(w_valid), .w_strb(w_strb)
);

`default_nettype wire

/* dv/tb_mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_stage;

	localparam int half_period = 20;
	localparam int reset_cycles = 16;
	localparam int wait_limit = 200;
	localparam int mem_bytes = 1024;

	logic clock;
	logic reset;
	logic in_valid;
	logic in_allowin;
	lsu_pkg::mem_op_e in_op;
	logic [lsu_pkg::addr_w-1:0] in_addr;
	logic [lsu_pkg::xlen-1:0] in_sdata;
	logic [lsu_pkg::reg_idx_w-1:0] in_rd;
	logic done;
	logic wb_en;
	logic [lsu_pkg::reg_idx_w-1:0] wb_rd;
	logic [lsu_pkg::xlen-1:0] wb_data;
	logic ar_valid, ar_ready, r_valid, r_ready;
	logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
	logic [lsu_pkg::addr_w-1:0] ar_addr, aw_addr;
	logic [lsu_pkg::bus_w-1:0] r_data, w_data;
	logic [lsu_pkg::strb_w-1:0] w_strb;

	// bus memory and the reference copy kept by the tests
	logic [7:0] mem [0:mem_bytes-1];
	logic [7:0] shadow [0:mem_bytes-1];
	logic [lsu_pkg::addr_w-1:0] ar_log [$];
	logic [lsu_pkg::addr_w-1:0] aw_log [$];
	logic [lsu_pkg::strb_w-1:0] wstrb_log [$];

	logic [31:0] lfsr = 32'hef39;
	logic rand_delay = 1'b0;
	int error_count = 0;
	int checks_done = 0;

	mem_stage_top u_mem_stage_top (.*);

	initial begin
		clock = 1'b0;
		forever #half_period clock = ~clock;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
		end
		return v;
	endfunction

	function automatic int ready_delay();
		if (rand_delay)
			return int'(rand_bits(2));
		return 0;
	endfunction

	function automatic logic [7:0] fill_byte(input logic [9:0] a);
		return a[7:0] ^ {a[9:8], a[9:8], a[9:8], a[9:8]} ^ 8'h5a;
	endfunction

	function automatic int op_bytes(input lsu_pkg::mem_op_e op);
		case (op)
			lsu_pkg::MEM_LW, lsu_pkg::MEM_SW: return 4;
			lsu_pkg::MEM_LH, lsu_pkg::MEM_LHU, lsu_pkg::MEM_SH: return 2;
			default: return 1;
		endcase
	endfunction

	function automatic logic op_is_load(input lsu_pkg::mem_op_e op);
		return op == lsu_pkg::MEM_LB || op == lsu_pkg::MEM_LH || op == lsu_pkg::MEM_LW ||
			op == lsu_pkg::MEM_LBU || op == lsu_pkg::MEM_LHU;
	endfunction

	// little-endian bytes from the reference copy, then extended
	function automatic logic [31:0] expected_load(input lsu_pkg::mem_op_e op,
			input logic [31:0] addr);
		logic [31:0] raw;
		logic [31:0] a;
		raw = '0;
		for (int i = 0; i < op_bytes(op); i++) begin
			a = addr + i;
			raw[8*i +: 8] = shadow[a[9:0]];
		end
		case (op)
			lsu_pkg::MEM_LB: return {{24{raw[7]}}, raw[7:0]};
			lsu_pkg::MEM_LH: return {{16{raw[15]}}, raw[15:0]};
			default:         return raw;
		endcase
	endfunction

	function automatic logic [63:0] read_dword(input logic [31:0] addr);
		logic [63:0] d;
		logic [9:0] base;
		base = {addr[9:3], 3'b000};
		for (int i = 0; i < 8; i++)
			d[8*i +: 8] = mem[base + i];
		return d;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$finish;
	endtask

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic check_data(input logic [lsu_pkg::xlen-1:0] got,
			input logic [lsu_pkg::xlen-1:0] exp, input string name);
		checks_done++;
		if (got !== exp) begin
			error_count++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_rd(input logic [lsu_pkg::reg_idx_w-1:0] got,
			input logic [lsu_pkg::reg_idx_w-1:0] exp, input string name);
		checks_done++;
		if (got !== exp) begin
			error_count++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_strb(input logic [lsu_pkg::strb_w-1:0] got,
			input logic [lsu_pkg::strb_w-1:0] exp, input string name);
		checks_done++;
		if (got !== exp) begin
			error_count++;
			$display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input logic [lsu_pkg::addr_w-1:0] got,
			input logic [lsu_pkg::addr_w-1:0] exp, input string name);
		checks_done++;
		if (got !== exp) begin
			error_count++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		checks_done++;
		if (got !== exp) begin
			error_count++;
			$display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string name);
		checks_done++;
		if (got != exp) begin
			error_count++;
			$display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic compare_memory();
		for (int a = 0; a < mem_bytes; a++) begin
			if (mem[a] !== shadow[a]) begin
				check_data(32'(mem[a]), 32'(shadow[a]), $sformatf("mem[%0h]", a));
				break;
			end
		end
	endtask

	// ------------------------------------------------------------
	// bus memory model
	// ------------------------------------------------------------
	always begin : bus_model
		logic ar_seen, ar_fire, r_fire, aw_seen, aw_fire, w_seen, w_fire, b_fire;
		logic [31:0] ar_a, aw_a, rd_addr, wr_addr;
		logic [63:0] w_d;
		logic [7:0] w_s;
		logic rd_pend, b_pend;
		int ar_wait, r_wait, aw_wait, w_wait, b_wait;
		// handshakes are sampled mid-cycle, acted on after the edge
		@(negedge clock);
		ar_seen = ar_valid;
		ar_fire = ar_valid && ar_ready;
		ar_a = ar_addr;
		r_fire = r_valid && r_ready;
		aw_seen = aw_valid;
		aw_fire = aw_valid && aw_ready;
		aw_a = aw_addr;
		w_seen = w_valid;
		w_fire = w_valid && w_ready;
		w_d = w_data;
		w_s = w_strb;
		b_fire = b_valid && b_ready;
		@(posedge clock);
		#2;
		if (reset) begin
			{ar_ready, r_valid, aw_ready, w_ready, b_valid} = '0;
			{rd_pend, b_pend} = '0;
			{ar_wait, r_wait, aw_wait, w_wait, b_wait} = '0;
		end else begin
			if (ar_fire) begin
				ar_ready = 1'b0;
				ar_log.push_back(ar_a);
				rd_addr = ar_a;
				rd_pend = 1'b1;
				r_wait = ready_delay();
				ar_wait = ready_delay();
			end else if (ar_seen && !ar_ready) begin
				if (ar_wait == 0)
					ar_ready = 1'b1;
				else
					ar_wait--;
			end
			if (r_fire) begin
				r_valid = 1'b0;
				rd_pend = 1'b0;
			end else if (rd_pend && !r_valid) begin
				if (r_wait == 0) begin
					r_valid = 1'b1;
					r_data = read_dword(rd_addr);
				end else
					r_wait--;
			end
			if (aw_fire) begin
				aw_ready = 1'b0;
				aw_log.push_back(aw_a);
				wr_addr = aw_a;
				aw_wait = ready_delay();
			end else if (aw_seen && !aw_ready) begin
				if (aw_wait == 0)
					aw_ready = 1'b1;
				else
					aw_wait--;
			end
			if (w_fire) begin
				w_ready = 1'b0;
				wstrb_log.push_back(w_s);
				for (int i = 0; i < 8; i++)
					if (w_s[i])
						mem[{wr_addr[9:3], 3'b000} + i] = w_d[8*i +: 8];
				b_pend = 1'b1;
				b_wait = ready_delay();
				w_wait = ready_delay();
			end else if (w_seen && !w_ready) begin
				if (w_wait == 0)
					w_ready = 1'b1;
				else
					w_wait--;
			end
			if (b_fire) begin
				b_valid = 1'b0;
				b_pend = 1'b0;
			end else if (b_pend && !b_valid) begin
				if (b_wait == 0)
					b_valid = 1'b1;
				else
					b_wait--;
			end
		end
	end

	// ------------------------------------------------------------
	// one request, start to done, with every check on the way
	// ------------------------------------------------------------
	task automatic run_op(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
			input logic [31:0] sdata, input logic [4:0] rd);
		int n;
		int guard;
		logic load;
		logic [31:0] b;
		logic [31:0] second_a;
		logic [7:0] first_s;
		logic [7:0] second_s;
		logic split;
		logic [31:0] exp;
		n = op_bytes(op);
		load = op_is_load(op);
		first_s = '0;
		second_s = '0;
		for (int i = 0; i < n; i++) begin
			b = addr + i;
			if (b[31:2] == addr[31:2])
				first_s[b[2:0]] = 1'b1;
			else
				second_s[b[2:0]] = 1'b1;
		end
		split = (second_s != '0);
		second_a = {addr[31:2], 2'b00} + 32'd4;
		exp = expected_load(op, addr);
		ar_log.delete();
		aw_log.delete();
		wstrb_log.delete();
		@(posedge clock);
		#2;
		in_valid = 1'b1;
		in_op = op;
		in_addr = addr;
		in_sdata = sdata;
		in_rd = rd;
		guard = 0;
		@(negedge clock);
		while (!in_allowin) begin
			guard++;
			if (guard > wait_limit)
				abort_run("timed out waiting for the request to be accepted");
			@(negedge clock);
		end
		@(posedge clock);
		#2;
		in_valid = 1'b0;
		guard = 0;
		@(negedge clock);
		while (!done) begin
			check_flag(in_allowin, 1'b0, "in_allowin");
			guard++;
			if (guard > wait_limit)
				abort_run("timed out waiting for done");
			@(negedge clock);
		end
		check_flag(wb_en, load, "wb_en");
		if (load) begin
			check_rd(wb_rd, rd, "wb_rd");
			check_data(wb_data, exp, "wb_data");
			check_count(ar_log.size(), split ? 2 : 1, "read transactions");
			check_count(aw_log.size(), 0, "write transactions");
			if (ar_log.size() > 0)
				check_addr(ar_log[0], addr, "ar_addr");
			if (split && ar_log.size() > 1)
				check_addr(ar_log[1], second_a, "second ar_addr");
		end else begin
			for (int i = 0; i < n; i++) begin
				b = addr + i;
				shadow[b[9:0]] = sdata[8*i +: 8];
			end
			check_count(aw_log.size(), split ? 2 : 1, "write transactions");
			check_count(wstrb_log.size(), split ? 2 : 1, "write beats");
			check_count(ar_log.size(), 0, "read transactions");
			if (aw_log.size() > 0 && wstrb_log.size() > 0) begin
				check_addr(aw_log[0], addr, "aw_addr");
				check_strb(wstrb_log[0], first_s, "w_strb");
			end
			if (split && aw_log.size() > 1 && wstrb_log.size() > 1) begin
				check_addr(aw_log[1], second_a, "second aw_addr");
				check_strb(wstrb_log[1], second_s, "second w_strb");
			end
			compare_memory();
		end
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic reset_outputs();
		@(negedge clock);
		check_flag(ar_valid, 1'b0, "ar_valid");
		check_flag(aw_valid, 1'b0, "aw_valid");
		check_flag(w_valid, 1'b0, "w_valid");
		check_flag(r_ready, 1'b0, "r_ready");
		check_flag(b_ready, 1'b0, "b_ready");
		check_flag(done, 1'b0, "done");
		check_flag(wb_en, 1'b0, "wb_en");
		check_flag(in_allowin, 1'b1, "in_allowin");
	endtask

	// bytes from 0x180 up have the top bit set
	task automatic aligned_loads();
		run_op(lsu_pkg::MEM_LW, 32'h100, 32'h0, 5'd1);
		run_op(lsu_pkg::MEM_LW, 32'h10c, 32'h0, 5'd2);
		run_op(lsu_pkg::MEM_LH, 32'h186, 32'h0, 5'd3);
		run_op(lsu_pkg::MEM_LHU, 32'h18a, 32'h0, 5'd4);
		run_op(lsu_pkg::MEM_LB, 32'h193, 32'h0, 5'd5);
		run_op(lsu_pkg::MEM_LBU, 32'h197, 32'h0, 5'd6);
	endtask

	task automatic split_loads();
		run_op(lsu_pkg::MEM_LW, 32'h121, 32'h0, 5'd7);
		run_op(lsu_pkg::MEM_LW, 32'h125, 32'h0, 5'd8);
		run_op(lsu_pkg::MEM_LW, 32'h126, 32'h0, 5'd9);
		run_op(lsu_pkg::MEM_LH, 32'h133, 32'h0, 5'd10);
		run_op(lsu_pkg::MEM_LH, 32'h137, 32'h0, 5'd11);
	endtask

	// every lane for each store size
	task automatic stores_all_lanes();
		for (int lane = 0; lane < 8; lane++) begin
			run_op(lsu_pkg::MEM_SB, 32'h200 + lane, rand_bits(32), 5'd0);
			run_op(lsu_pkg::MEM_SH, 32'h240 + lane * 3, rand_bits(32), 5'd0);
			run_op(lsu_pkg::MEM_SW, 32'h280 + lane * 3, rand_bits(32), 5'd0);
		end
	endtask

	task automatic random_stream();
		lsu_pkg::mem_op_e op;
		logic [31:0] addr;
		logic [31:0] sdata;
		logic [4:0] rd;
		rand_delay = 1'b1;
		for (int k = 0; k < 48; k++) begin
			op = lsu_pkg::mem_op_e'(rand_bits(3));
			addr = 32'h300 + rand_bits(5);
			sdata = rand_bits(32);
			rd = 5'(rand_bits(5));
			run_op(op, addr, sdata, rd);
		end
		rand_delay = 1'b0;
	endtask

	initial begin
		int total;
		for (int a = 0; a < mem_bytes; a++) begin
			mem[a] = fill_byte(10'(a));
			shadow[a] = fill_byte(10'(a));
		end
		reset = 1'b1;
		in_valid = 1'b0;
		in_op = lsu_pkg::MEM_LB;
		in_addr = '0;
		in_sdata = '0;
		in_rd = '0;
		{ar_ready, r_valid, aw_ready, w_ready, b_valid} = '0;
		r_data = '0;
		repeat (reset_cycles) @(posedge clock);
		#2;
		reset = 1'b0;
		reset_outputs();
		aligned_loads();
		split_loads();
		stores_all_lanes();
		random_stream();
		total = error_count + u_mem_stage_top.u_props.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d", checks_done,
			error_count, u_mem_stage_top.u_props.fail_count);
		if (total == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/lsu/axi_read_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_read_fsm #(
	parameter int ADDR_W = lsu_pkg::addr_w,
	parameter int BUS_W  = lsu_pkg::bus_w
) (
	input  wire               clock,
	input  wire               reset,
	input  wire               rd_start,
	access_if.user            plan,
	output logic              ar_valid,
	input  wire               ar_ready,
	output logic [ADDR_W-1:0] ar_addr,
	input  wire               r_valid,
	output logic              r_ready,
	input  wire [BUS_W-1:0]   r_data,
	output logic [BUS_W-1:0]  first_beat,
	output logic              second_phase,
	output logic              rd_done
);

	lsu_pkg::rd_state_e state;
	lsu_pkg::rd_state_e state_nx;
	logic               r_fire;
	logic               more;

	assign r_fire = r_valid && r_ready;
	// one more transaction follows this beat
	assign more   = plan.need_second && !second_phase;

	always_comb begin
		state_nx = state;
		case (state)
			lsu_pkg::RD_IDLE:
				if (rd_start)
					state_nx = lsu_pkg::RD_WAIT_AR;
			lsu_pkg::RD_WAIT_AR:
				if (ar_ready)
					state_nx = lsu_pkg::RD_WAIT_R;
			lsu_pkg::RD_WAIT_R:
				if (r_valid)
					state_nx = more ? lsu_pkg::RD_IDLE2 : lsu_pkg::RD_IDLE;
			lsu_pkg::RD_IDLE2:
				state_nx = lsu_pkg::RD_WAIT_AR;
			default:
				state_nx = lsu_pkg::RD_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state        <= lsu_pkg::RD_IDLE;
			second_phase <= 1'b0;
		end else begin
			state <= state_nx;
			if (r_fire)
				second_phase <= more;
		end
	end

	// low half of a split read, kept for the gather
	always_ff @(posedge clock) begin
		if (r_fire && !second_phase)
			first_beat <= r_data;
	end

	assign ar_valid = (state == lsu_pkg::RD_WAIT_AR);
	assign ar_addr  = second_phase ? plan.second_addr : plan.first_addr;
	assign r_ready  = (state == lsu_pkg::RD_WAIT_R);
	assign rd_done  = r_fire && !more;

endmodule

`default_nettype wire

/* hw/lsu/axi_write_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_write_fsm #(
	parameter int ADDR_W = lsu_pkg::addr_w,
	parameter int BUS_W  = lsu_pkg::bus_w
) (
	input  wire                clock,
	input  wire                reset,
	input  wire                wr_start,
	access_if.user             plan,
	output logic               aw_valid,
	input  wire                aw_ready,
	output logic [ADDR_W-1:0]  aw_addr,
	output logic               w_valid,
	input  wire                w_ready,
	output logic [BUS_W-1:0]   w_data,
	output logic [BUS_W/8-1:0] w_strb,
	input  wire                b_valid,
	output logic               b_ready,
	output logic               wr_done
);

	lsu_pkg::wr_state_e state;
	lsu_pkg::wr_state_e state_nx;
	logic               second;
	logic               b_fire;
	logic               more;

	assign b_fire = b_valid && b_ready;
	assign more   = plan.need_second && !second;

	// ------------------------------------------------------------
	// AW, then W, then B
	// ------------------------------------------------------------
	always_comb begin
		state_nx = state;
		case (state)
			lsu_pkg::WR_IDLE:
				if (wr_start)
					state_nx = lsu_pkg::WR_WAIT_AW;
			lsu_pkg::WR_WAIT_AW:
				if (aw_ready)
					state_nx = lsu_pkg::WR_WAIT_W;
			lsu_pkg::WR_WAIT_W:
				if (w_ready)
					state_nx = lsu_pkg::WR_WAIT_B;
			lsu_pkg::WR_WAIT_B:
				if (b_valid)
					state_nx = more ? lsu_pkg::WR_IDLE2 : lsu_pkg::WR_IDLE;
			lsu_pkg::WR_IDLE2:
				state_nx = lsu_pkg::WR_WAIT_AW;
			default:
				state_nx = lsu_pkg::WR_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state  <= lsu_pkg::WR_IDLE;
			second <= 1'b0;
		end else begin
			state <= state_nx;
			if (b_fire)
				second <= more;
		end
	end

	assign aw_valid = (state == lsu_pkg::WR_WAIT_AW);
	assign w_valid  = (state == lsu_pkg::WR_WAIT_W);
	assign b_ready  = (state == lsu_pkg::WR_WAIT_B);

	// phase picks address and strobe, data is the same on both beats
	assign aw_addr = second ? plan.second_addr : plan.first_addr;
	assign w_strb  = second ? plan.second_strb : plan.first_strb;
	assign w_data  = plan.wdata;

	assign wr_done = b_fire && !more;

endmodule

`default_nettype wire

/* hw/lsu/lane_align.sv */
`timescale 1ns/10ps
`default_nettype none

module lane_align #(
	parameter int ADDR_W = lsu_pkg::addr_w,
	parameter int XLEN   = lsu_pkg::xlen,
	parameter int BUS_W  = lsu_pkg::bus_w
) (
	input  wire lsu_pkg::mem_op_e op_q,
	input  wire [ADDR_W-1:0]      addr_q,
	input  wire [XLEN-1:0]        sdata_q,
	access_if.planner             plan
);

	localparam int STRB_W = BUS_W / 8;
	localparam int LANE_W = $clog2(STRB_W);

	logic [LANE_W-1:0]     lane;
	logic [1:0]            grp_off;
	lsu_pkg::grp_mask_t    mask;
	logic [7:0]            spread;
	lsu_pkg::grp_mask_t    first_grp;
	lsu_pkg::grp_mask_t    second_grp;
	logic [ADDR_W-1:0]     next_grp_addr;
	logic [BUS_W-1:0]      sdata_ext;
	logic [2*BUS_W-1:0]    rot_dbl;

	assign lane    = addr_q[LANE_W-1:0];
	assign grp_off = addr_q[1:0];
	assign mask    = lsu_pkg::size_mask(op_q);

	// ------------------------------------------------------------
	// split decision
	// ------------------------------------------------------------
	// bytes shifted past bit 3 fall into the next group
	assign spread     = {4'b0000, mask} << grp_off;
	assign first_grp  = spread[3:0];
	assign second_grp = spread[7:4];

	assign plan.op          = op_q;
	assign plan.need_second = |second_grp;

	// ------------------------------------------------------------
	// addresses
	// ------------------------------------------------------------
	assign next_grp_addr    = {addr_q[ADDR_W-1:2], 2'b00} + ADDR_W'(4);
	assign plan.first_addr  = addr_q;
	assign plan.second_addr = next_grp_addr;

	// ------------------------------------------------------------
	// strobes
	// ------------------------------------------------------------
	// each group mask lands on the group its address selects
	assign plan.first_strb  = STRB_W'(first_grp) << {lane[LANE_W-1:2], 2'b00};
	assign plan.second_strb = STRB_W'(second_grp) << {next_grp_addr[LANE_W-1:2], 2'b00};

	// ------------------------------------------------------------
	// store data
	// ------------------------------------------------------------
	// rotate left by 8*lane, low bytes wrap round to the top
	assign sdata_ext  = BUS_W'(sdata_q);
	assign rot_dbl    = {sdata_ext, sdata_ext} << {lane, 3'b000};
	assign plan.wdata = rot_dbl[2*BUS_W-1:BUS_W];

endmodule

`default_nettype wire

/* hw/lsu/load_extract.sv */
`timescale 1ns/10ps
`default_nettype none

module load_extract #(
	parameter int XLEN  = lsu_pkg::xlen,
	parameter int BUS_W = lsu_pkg::bus_w
) (
	access_if.user          plan,
	input  wire [BUS_W-1:0] first_beat,
	input  wire [BUS_W-1:0] r_data,
	input  wire             second_phase,
	output logic [XLEN-1:0] wb_data
);

	localparam int GROUPS = BUS_W / 32;

	logic [BUS_W-1:0] first_src;
	logic [31:0]      gathered;
	logic [63:0]      rot_dbl;
	logic [31:0]      aligned;

	// a split read has its first beat parked in the engine
	assign first_src = second_phase ? first_beat : r_data;

	// byte k of the group comes from whichever lane is strobed
	always_comb begin
		gathered = '0;
		for (int g = 0; g < GROUPS; g++) begin
			for (int k = 0; k < 4; k++) begin
				if (plan.first_strb[g*4+k])
					gathered[k*8 +: 8] = gathered[k*8 +: 8] | first_src[(g*4+k)*8 +: 8];
				if (plan.second_strb[g*4+k])
					gathered[k*8 +: 8] = gathered[k*8 +: 8] | r_data[(g*4+k)*8 +: 8];
			end
		end
	end

	// undo the lane rotation within the group
	assign rot_dbl = {gathered, gathered} >> {plan.first_addr[1:0], 3'b000};
	assign aligned = rot_dbl[31:0];

	always_comb begin
		wb_data = '0;
		if (lsu_pkg::is_load(plan.op)) begin
			case (plan.op)
				lsu_pkg::MEM_LB:  wb_data = XLEN'(signed'(aligned[7:0]));
				lsu_pkg::MEM_LBU: wb_data = XLEN'(aligned[7:0]);
				lsu_pkg::MEM_LH:  wb_data = XLEN'(signed'(aligned[15:0]));
				lsu_pkg::MEM_LHU: wb_data = XLEN'(aligned[15:0]);
				default:          wb_data = XLEN'(aligned);
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/mem_stage_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage_ctrl #(
	parameter int ADDR_W = lsu_pkg::addr_w,
	parameter int XLEN   = lsu_pkg::xlen
) (
	input  wire                           clock,
	input  wire                           reset,
	input  wire                           in_valid,
	output logic                          in_allowin,
	input  wire lsu_pkg::mem_op_e         in_op,
	input  wire [ADDR_W-1:0]              in_addr,
	input  wire [XLEN-1:0]                in_sdata,
	input  wire [lsu_pkg::reg_idx_w-1:0]  in_rd,
	output lsu_pkg::mem_op_e              op_q,
	output logic [ADDR_W-1:0]             addr_q,
	output logic [XLEN-1:0]               sdata_q,
	output logic                          rd_start,
	output logic                          wr_start,
	input  wire                           rd_done,
	input  wire                           wr_done,
	output logic                          done,
	output logic                          wb_en,
	output logic [lsu_pkg::reg_idx_w-1:0] wb_rd
);

	logic stage_valid;
	logic start_q;
	logic accept;

	assign accept     = in_valid && in_allowin;
	assign in_allowin = !stage_valid || done;

	// completion comes from whichever engine owns the op
	assign done  = stage_valid && (lsu_pkg::is_load(op_q) ? rd_done : wr_done);
	assign wb_en = done && lsu_pkg::is_load(op_q);

	// one start pulse, the cycle after accept
	assign rd_start = start_q && lsu_pkg::is_load(op_q);
	assign wr_start = start_q && lsu_pkg::is_store(op_q);

	always_ff @(posedge clock) begin
		if (reset) begin
			stage_valid <= 1'b0;
			start_q     <= 1'b0;
		end else begin
			if (in_allowin)
				stage_valid <= in_valid;
			start_q <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			op_q    <= in_op;
			addr_q  <= in_addr;
			sdata_q <= in_sdata;
			wb_rd   <= in_rd;
		end
	end

endmodule

`default_nettype wire

/* hw/mem_stage_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage_top #(
	parameter int ADDR_W = lsu_pkg::addr_w,
	parameter int XLEN   = lsu_pkg::xlen,
	parameter int BUS_W  = lsu_pkg::bus_w
) (
	input  wire                           clock,
	input  wire                           reset,
	// request side
	input  wire                           in_valid,
	output logic                          in_allowin,
	input  wire lsu_pkg::mem_op_e         in_op,
	input  wire [ADDR_W-1:0]              in_addr,
	input  wire [XLEN-1:0]                in_sdata,
	input  wire [lsu_pkg::reg_idx_w-1:0]  in_rd,
	// completion and writeback
	output logic                          done,
	output logic                          wb_en,
	output logic [lsu_pkg::reg_idx_w-1:0] wb_rd,
	output logic [XLEN-1:0]               wb_data,
	// read channels
	output logic                          ar_valid,
	input  wire                           ar_ready,
	output logic [ADDR_W-1:0]             ar_addr,
	input  wire                           r_valid,
	output logic                          r_ready,
	input  wire [BUS_W-1:0]               r_data,
	// write channels
	output logic                          aw_valid,
	input  wire                           aw_ready,
	output logic [ADDR_W-1:0]             aw_addr,
	output logic                          w_valid,
	input  wire                           w_ready,
	output logic [BUS_W-1:0]              w_data,
	output logic [BUS_W/8-1:0]            w_strb,
	input  wire                           b_valid,
	output logic                          b_ready
);

	lsu_pkg::mem_op_e  op_q;
	logic [ADDR_W-1:0] addr_q;
	logic [XLEN-1:0]   sdata_q;
	logic              rd_start;
	logic              wr_start;
	logic              rd_done;
	logic              wr_done;
	logic [BUS_W-1:0]  first_beat;
	logic              second_phase;

	access_if #(.ADDR_W(ADDR_W), .BUS_W(BUS_W)) plan_if ();

	mem_stage_ctrl #(.ADDR_W(ADDR_W), .XLEN(XLEN)) u_ctrl (
		.clock, .reset, .in_valid, .in_allowin, .in_op, .in_addr, .in_sdata, .in_rd,
		.op_q, .addr_q, .sdata_q, .rd_start, .wr_start, .rd_done, .wr_done,
		.done, .wb_en, .wb_rd
	);

	lane_align #(.ADDR_W(ADDR_W), .XLEN(XLEN), .BUS_W(BUS_W)) u_lane_align (
		.op_q, .addr_q, .sdata_q, .plan(plan_if.planner)
	);

	axi_read_fsm #(.ADDR_W(ADDR_W), .BUS_W(BUS_W)) u_read (
		.clock, .reset, .rd_start, .plan(plan_if.user),
		.ar_valid, .ar_ready, .ar_addr, .r_valid, .r_ready, .r_data,
		.first_beat, .second_phase, .rd_done
	);

	axi_write_fsm #(.ADDR_W(ADDR_W), .BUS_W(BUS_W)) u_write (
		.clock, .reset, .wr_start, .plan(plan_if.user),
		.aw_valid, .aw_ready, .aw_addr, .w_valid, .w_ready, .w_data, .w_strb,
		.b_valid, .b_ready, .wr_done
	);

	load_extract #(.XLEN(XLEN), .BUS_W(BUS_W)) u_extract (
		.plan(plan_if.user), .first_beat, .r_data, .second_phase, .wb_data
	);

endmodule

`default_nettype wire
